/* src/ex_pkg.sv */
package ex_pkg;

	parameter int XLEN = 64;
	parameter int WLEN = 32; // W-type operand width

	typedef logic [XLEN-1:0] data_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [11:0] b_imm_t; // offset bits 12:1
	typedef logic [5:0] shamt_t;

	typedef enum logic [4:0] {
		alu_add = 5'd0,
		alu_addw = 5'd1,
		alu_sll = 5'd2,
		alu_sllw = 5'd3,
		alu_sra = 5'd4,
		alu_sraw = 5'd5,
		alu_srl = 5'd6,
		alu_srlw = 5'd7,
		alu_and = 5'd8,
		alu_or = 5'd9,
		alu_xor = 5'd10,
		alu_slt = 5'd11,
		alu_sltu = 5'd12,
		alu_eq = 5'd13,
		alu_ne = 5'd14,
		alu_sge = 5'd15,
		alu_sgeu = 5'd16,
		alu_sub = 5'd17,
		alu_subw = 5'd18,
		alu_mul = 5'd19, // low half, unsigned
		alu_mulh = 5'd20, // high half, signed x signed
		alu_mulhu = 5'd21, // high half, unsigned
		alu_mulw = 5'd22 // low word, sign extended
	} alu_op_t;

	// 23 and up are unused, they yield zero

endpackage

/* src/ex_alu.sv */
module ex_alu import ex_pkg::*; #(
	parameter int XLEN = ex_pkg::XLEN
) (
	input alu_op_t op,
	input data_t src_a,
	input data_t src_b,
	output data_t alu_result
);

	shamt_t shamt;
	logic [4:0] shamt_w;
	logic [WLEN-1:0] word_res;
	logic word_op;

	assign shamt = src_b[5:0];
	assign shamt_w = src_b[4:0]; // word shifts ignore bit 5

	always_comb begin
		word_res = '0;
		word_op = 1'b0;
		alu_result = '0; // mul and unused codes
		case (op)
			alu_add: alu_result = src_a + src_b;
			alu_sub: alu_result = src_a - src_b;
			alu_sll: alu_result = src_a << shamt;
			alu_srl: alu_result = src_a >> shamt;
			alu_sra: alu_result = $signed(src_a) >>> shamt;
			alu_and: alu_result = src_a & src_b;
			alu_or: alu_result = src_a | src_b;
			alu_xor: alu_result = src_a ^ src_b;
			alu_slt: begin
				alu_result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			end
			alu_sltu: begin
				alu_result = {{(XLEN-1){1'b0}}, src_a < src_b};
			end
			alu_eq: begin
				alu_result = {{(XLEN-1){1'b0}}, src_a == src_b};
			end
			alu_ne: begin
				alu_result = {{(XLEN-1){1'b0}}, src_a != src_b};
			end
			alu_sge: begin
				alu_result = {{(XLEN-1){1'b0}}, $signed(src_a) >= $signed(src_b)};
			end
			alu_sgeu: begin
				alu_result = {{(XLEN-1){1'b0}}, src_a >= src_b};
			end
			alu_addw: begin
				word_res = src_a[WLEN-1:0] + src_b[WLEN-1:0];
				word_op = 1'b1;
			end
			alu_subw: begin
				word_res = src_a[WLEN-1:0] - src_b[WLEN-1:0];
				word_op = 1'b1;
			end
			alu_sllw: begin
				word_res = src_a[WLEN-1:0] << shamt_w;
				word_op = 1'b1;
			end
			alu_srlw: begin
				word_res = src_a[WLEN-1:0] >> shamt_w;
				word_op = 1'b1;
			end
			alu_sraw: begin
				word_res = $signed(src_a[WLEN-1:0]) >>> shamt_w;
				word_op = 1'b1;
			end
			default: begin
				alu_result = '0;
			end
		endcase

		// W-type results are sign extended from bit 31
		if (word_op) begin
			alu_result = {{(XLEN-WLEN){word_res[WLEN-1]}}, word_res};
		end
	end

endmodule

/* src/ex_multiplier.sv */
module ex_multiplier import ex_pkg::*; #(
	parameter int XLEN = ex_pkg::XLEN
) (
	input logic clk,
	input logic reset,
	input logic mul_start,
	input logic mul_signed_a,
	input logic mul_signed_b,
	input data_t mul_a,
	input data_t mul_b,
	input logic mul_take,
	output logic mul_busy,
	output logic mul_done,
	output data_t product_hi,
	output data_t product_lo
);

	localparam int CW = $clog2(XLEN + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} state_t;

	state_t state;
	logic [2*XLEN-1:0] acc; // {partial sum, remaining multiplier bits}
	data_t mcand;
	logic neg;
	logic [CW-1:0] cnt;
	logic last_step;

	logic a_neg;
	logic b_neg;
	data_t abs_a;
	data_t abs_b;
	logic [XLEN:0] sum;

	assign a_neg = mul_signed_a & mul_a[XLEN-1];
	assign b_neg = mul_signed_b & mul_b[XLEN-1];
	assign abs_a = a_neg ? -mul_a : mul_a; // most negative stays as 2^(XLEN-1)
	assign abs_b = b_neg ? -mul_b : mul_b;

	// add multiplicand when current multiplier bit is set
	assign sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, mcand} : '0);

	assign last_step = (cnt == CW'(XLEN)); // sign fixup cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (mul_start) begin
						state <= st_run;
					end
				end
				st_run: begin
					if (last_step) begin
						state <= st_done;
					end
				end
				st_done: begin
					if (mul_take) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && mul_start) begin
			mcand <= abs_a;
			acc <= {{XLEN{1'b0}}, abs_b};
			neg <= a_neg ^ b_neg;
			cnt <= '0;
		end else if (state == st_run) begin
			if (last_step) begin
				if (neg) begin
					acc <= -acc;
				end
			end else begin
				acc <= {sum, acc[XLEN-1:1]};
			end
			cnt <= cnt + 1'b1;
		end
	end

	assign mul_busy = (state == st_run);
	assign mul_done = (state == st_done);
	assign product_hi = acc[2*XLEN-1:XLEN];
	assign product_lo = acc[XLEN-1:0];

endmodule

/* src/ex_control.sv */
module ex_control import ex_pkg::*; #(
	parameter int XLEN = ex_pkg::XLEN
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input addr_t pc,
	input alu_op_t op,
	input data_t src_a,
	input data_t src_b,
	input logic is_branch,
	input b_imm_t b_imm,
	input data_t store_data,
	input logic mem_write,
	input logic wb_sel,
	input logic reg_write,
	input reg_addr_t rd,
	input data_t alu_result,
	output logic mul_start,
	output logic mul_signed_a,
	output logic mul_signed_b,
	output data_t mul_a,
	output data_t mul_b,
	output logic mul_take,
	input logic mul_busy,
	input logic mul_done,
	input data_t product_hi,
	input data_t product_lo,
	output logic out_valid,
	input logic out_ready,
	output addr_t out_pc,
	output data_t out_result,
	output data_t out_store_data,
	output logic out_mem_write,
	output logic out_wb_sel,
	output logic out_reg_write,
	output reg_addr_t out_rd,
	output logic out_branch_taken,
	output addr_t out_branch_target
);

	logic is_mul;
	logic is_mulw;
	logic slot_free;
	logic xfer;
	data_t result;
	addr_t branch_target;
	logic branch_taken;

	assign is_mul = (op == alu_mul) || (op == alu_mulh) || (op == alu_mulhu) || is_mulw;
	assign is_mulw = (op == alu_mulw);

	assign slot_free = !out_valid || out_ready;

	// mul ops wait for the held product
	assign in_ready = is_mul ? (mul_done && slot_free) : slot_free;
	assign xfer = in_valid && in_ready;

	assign mul_start = in_valid && is_mul && !mul_busy && !mul_done;
	assign mul_take = xfer && is_mul;
	assign mul_signed_a = (op == alu_mulh) || is_mulw;
	assign mul_signed_b = (op == alu_mulh) || is_mulw;
	assign mul_a = is_mulw ? {{(XLEN-WLEN){src_a[WLEN-1]}}, src_a[WLEN-1:0]} : src_a;
	assign mul_b = is_mulw ? {{(XLEN-WLEN){src_b[WLEN-1]}}, src_b[WLEN-1:0]} : src_b;

	always_comb begin
		case (op)
			alu_mul: result = product_lo;
			alu_mulh: result = product_hi;
			alu_mulhu: result = product_hi;
			alu_mulw: result = {{(XLEN-WLEN){product_lo[WLEN-1]}}, product_lo[WLEN-1:0]};
			default: result = alu_result;
		endcase
	end

	assign branch_target = pc + {{(XLEN-13){b_imm[11]}}, b_imm, 1'b0};
	assign branch_taken = is_branch && (result != '0);

	// output slot control
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_mem_write <= 1'b0;
			out_reg_write <= 1'b0;
			out_branch_taken <= 1'b0;
		end else if (xfer) begin
			out_valid <= 1'b1;
			out_mem_write <= mem_write;
			out_reg_write <= reg_write;
			out_branch_taken <= branch_taken;
		end else if (out_ready) begin
			out_valid <= 1'b0; // drained, nothing new
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (xfer) begin
			out_pc <= pc;
			out_result <= result;
			out_store_data <= store_data;
			out_wb_sel <= wb_sel;
			out_rd <= rd;
			out_branch_target <= branch_target;
		end
	end

endmodule

/* src/ex_stage.sv */
module ex_stage import ex_pkg::*; #(
	parameter int XLEN = ex_pkg::XLEN
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input addr_t pc,
	input alu_op_t op,
	input data_t src_a,
	input data_t src_b,
	input logic is_branch,
	input b_imm_t b_imm,
	input data_t store_data,
	input logic mem_write,
	input logic wb_sel,
	input logic reg_write,
	input reg_addr_t rd,
	output logic out_valid,
	input logic out_ready,
	output addr_t out_pc,
	output data_t out_result,
	output data_t out_store_data,
	output logic out_mem_write,
	output logic out_wb_sel,
	output logic out_reg_write,
	output reg_addr_t out_rd,
	output logic out_branch_taken,
	output addr_t out_branch_target
);

	data_t alu_result;
	logic mul_start;
	logic mul_signed_a;
	logic mul_signed_b;
	data_t mul_a;
	data_t mul_b;
	logic mul_take;
	logic mul_busy;
	logic mul_done;
	data_t product_hi;
	data_t product_lo;

	ex_alu #(
		.XLEN(XLEN)
	) i_alu (
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.alu_result(alu_result)
	);

	ex_multiplier #(
		.XLEN(XLEN)
	) i_multiplier (
		.clk(clk),
		.reset(reset),
		.mul_start(mul_start),
		.mul_signed_a(mul_signed_a),
		.mul_signed_b(mul_signed_b),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_take(mul_take),
		.mul_busy(mul_busy),
		.mul_done(mul_done),
		.product_hi(product_hi),
		.product_lo(product_lo)
	);

	ex_control #(
		.XLEN(XLEN)
	) i_control (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.pc(pc),
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.is_branch(is_branch),
		.b_imm(b_imm),
		.store_data(store_data),
		.mem_write(mem_write),
		.wb_sel(wb_sel),
		.reg_write(reg_write),
		.rd(rd),
		.alu_result(alu_result),
		.mul_start(mul_start),
		.mul_signed_a(mul_signed_a),
		.mul_signed_b(mul_signed_b),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_take(mul_take),
		.mul_busy(mul_busy),
		.mul_done(mul_done),
		.product_hi(product_hi),
		.product_lo(product_lo),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pc(out_pc),
		.out_result(out_result),
		.out_store_data(out_store_data),
		.out_mem_write(out_mem_write),
		.out_wb_sel(out_wb_sel),
		.out_reg_write(out_reg_write),
		.out_rd(out_rd),
		.out_branch_taken(out_branch_taken),
		.out_branch_target(out_branch_target)
	);

endmodule

/* verification/ex_checker.sv */
module ex_checker import ex_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_ready,
	input logic [4:0] op,
	input addr_t pc,
	input data_t src_a,
	input data_t src_b,
	input logic is_branch,
	input b_imm_t b_imm,
	input data_t store_data,
	input logic mem_write,
	input logic wb_sel,
	input logic reg_write,
	input reg_addr_t rd,
	input logic out_valid,
	input logic out_ready,
	input addr_t out_pc,
	input data_t out_result,
	input data_t out_store_data,
	input logic out_mem_write,
	input logic out_wb_sel,
	input logic out_reg_write,
	input reg_addr_t out_rd,
	input logic out_branch_taken,
	input addr_t out_branch_target,
	output int check_errors,
	output int transfers,
	output int pending
);
	timeunit 1ns;
	timeprecision 1ps;

	addr_t pc_q[$];
	data_t result_q[$];
	data_t store_q[$];
	addr_t target_q[$];
	logic [8:0] ctrl_q[$]; // taken, mem_write, wb_sel, reg_write, rd
	logic after_reset = 1'b0;

	initial begin
		check_errors = 0;
		transfers = 0;
		pending = 0;
	end

	function automatic data_t sext_word(input logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	// mul slices come from full 128-bit products
	function automatic void expected_outputs(input logic [4:0] code, input data_t a,
			input data_t b, input addr_t cur_pc, input logic branch, input b_imm_t imm,
			output data_t res, output logic taken, output addr_t target);
		logic [127:0] prod_u;
		logic [127:0] prod_s;
		logic [63:0] offset;
		prod_u = {64'b0, a} * {64'b0, b};
		prod_s = {{64{a[63]}}, a} * {{64{b[63]}}, b};
		res = '0;
		case (code)
			alu_add: res = a + b;
			alu_sub: res = a - b;
			alu_sll: res = a << b[5:0];
			alu_srl: res = a >> b[5:0];
			alu_sra: res = $signed(a) >>> b[5:0];
			alu_and: res = a & b;
			alu_or: res = a | b;
			alu_xor: res = a ^ b;
			alu_slt: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			alu_sltu: res = (a < b) ? 64'd1 : 64'd0;
			alu_eq: res = (a == b) ? 64'd1 : 64'd0;
			alu_ne: res = (a != b) ? 64'd1 : 64'd0;
			alu_sge: res = ($signed(a) >= $signed(b)) ? 64'd1 : 64'd0;
			alu_sgeu: res = (a >= b) ? 64'd1 : 64'd0;
			alu_addw: res = sext_word(a[31:0] + b[31:0]);
			alu_subw: res = sext_word(a[31:0] - b[31:0]);
			alu_sllw: res = sext_word(a[31:0] << b[4:0]);
			alu_srlw: res = sext_word(a[31:0] >> b[4:0]);
			alu_sraw: res = sext_word($signed(a[31:0]) >>> b[4:0]);
			alu_mul: res = prod_u[63:0];
			alu_mulh: res = prod_s[127:64];
			alu_mulhu: res = prod_u[127:64];
			alu_mulw: res = sext_word(prod_s[31:0]);
			default: res = '0;
		endcase
		offset = {{52{imm[11]}}, imm};
		target = cur_pc + (offset << 1); // offset counts halfwords
		taken = branch && (res != 0);
	endfunction

	task automatic compare_field(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			check_errors++;
		end
	endtask

	always @(posedge clk) begin : watch_edge
		data_t res;
		logic taken;
		addr_t target;
		logic [8:0] ctrl;
		if (reset) begin
			if (after_reset && out_valid !== 1'b0) begin
				$display("out_valid is not low while reset is asserted");
				check_errors++;
			end
			after_reset = 1'b1;
		end else begin
			if (after_reset && out_valid !== 1'b0) begin
				$display("out_valid is high in the first cycle after reset");
				check_errors++;
			end
			after_reset = 1'b0;
			if (in_valid && in_ready) begin
				expected_outputs(op, src_a, src_b, pc, is_branch, b_imm, res, taken, target);
				pc_q.push_back(pc);
				result_q.push_back(res);
				store_q.push_back(store_data);
				target_q.push_back(target);
				ctrl_q.push_back({taken, mem_write, wb_sel, reg_write, rd});
			end
			if (out_valid && out_ready) begin
				if (pc_q.size() == 0) begin
					$display("output transfer without any accepted input waiting for it");
					check_errors++;
				end else begin
					compare_field("out_pc", pc_q.pop_front(), out_pc);
					compare_field("out_result", result_q.pop_front(), out_result);
					compare_field("out_store_data", store_q.pop_front(), out_store_data);
					compare_field("out_branch_target", target_q.pop_front(), out_branch_target);
					ctrl = ctrl_q.pop_front();
					compare_field("out_branch_taken", ctrl[8], out_branch_taken);
					compare_field("out_mem_write", ctrl[7], out_mem_write);
					compare_field("out_wb_sel", ctrl[6], out_wb_sel);
					compare_field("out_reg_write", ctrl[5], out_reg_write);
					compare_field("out_rd", ctrl[4:0], out_rd);
					transfers++;
				end
			end
			pending = pc_q.size();
		end
	end

endmodule

/* verification/tb_ex_stage.sv */
module tb_ex_stage import ex_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ITEMS = 400;
	localparam int IN_TIMEOUT = 300; // cycles, covers a full multiply
	localparam int DRAIN_TIMEOUT = 300;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	addr_t pc;
	alu_op_t op;
	data_t src_a;
	data_t src_b;
	logic is_branch;
	b_imm_t b_imm;
	data_t store_data;
	logic mem_write;
	logic wb_sel;
	logic reg_write;
	reg_addr_t rd;
	logic out_valid;
	logic out_ready;
	addr_t out_pc;
	data_t out_result;
	data_t out_store_data;
	logic out_mem_write;
	logic out_wb_sel;
	logic out_reg_write;
	reg_addr_t out_rd;
	logic out_branch_taken;
	addr_t out_branch_target;
	int check_errors;
	int transfers;
	int pending;
	int tb_errors = 0;
	logic [63:0] rng_state = 64'd52;

	ex_stage #(
		.XLEN(XLEN)
	) i_dut (.*);

	ex_checker i_checker (.*);

	function automatic logic [63:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 7;
		rng_state ^= rng_state << 17;
		return rng_state;
	endfunction

	function automatic data_t pick_operand();
		logic [63:0] r;
		r = next_rand();
		case (r[3:0])
			4'd0: return '0;
			4'd1: return '1;
			4'd2: return 64'h8000_0000_0000_0000; // most negative
			4'd3: return 64'h0000_0000_7fff_ffff;
			4'd4: return 64'hffff_ffff_8000_0000;
			4'd5: return 64'h0000_0000_8000_0000;
			default: return next_rand();
		endcase
	endfunction

	function automatic alu_op_t pick_op();
		logic [63:0] r;
		r = next_rand();
		if (r[4:0] == 5'd0) begin
			return alu_op_t'(5'd23 + r[12:10]); // unused codes
		end
		return alu_op_t'(r[20:8] % 23);
	endfunction

	task automatic send_item();
		int waited;
		logic accepted;
		pc = next_rand();
		op = pick_op();
		src_a = pick_operand();
		src_b = pick_operand();
		is_branch = (next_rand() % 4) == 0;
		b_imm = 12'(next_rand());
		store_data = next_rand();
		{mem_write, wb_sel, reg_write, rd} = 8'(next_rand());
		in_valid = 1'b1;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < IN_TIMEOUT) begin
			@(posedge clk);
			accepted = in_ready;
			waited++;
			@(negedge clk);
			out_ready = (next_rand() % 4) != 0;
		end
		if (!accepted) begin
			$display("in_ready stayed low for %0d cycles, input never accepted", IN_TIMEOUT);
			tb_errors++;
		end
		if ((next_rand() % 8) == 0) begin
			in_valid = 1'b0; // idle gap
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		int waited;
		reset = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b0;
		pc = '0;
		op = alu_add;
		src_a = '0;
		src_b = '0;
		is_branch = 1'b0;
		b_imm = '0;
		store_data = '0;
		mem_write = 1'b0;
		wb_sel = 1'b0;
		reg_write = 1'b0;
		rd = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			send_item();
			if (tb_errors != 0) begin
				break;
			end
		end
		in_valid = 1'b0;
		out_ready = 1'b1;
		waited = 0;
		while ((out_valid || pending != 0) && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (out_valid || pending != 0) begin
			$display("drain timed out with %0d results still expected", pending);
			tb_errors++;
		end
		if (transfers != NUM_ITEMS) begin
			$display("only %0d of %0d items came out of the stage", transfers, NUM_ITEMS);
			tb_errors++;
		end
		$display("errors %0d (checker %0d, testbench %0d), transfers %0d",
			check_errors + tb_errors, check_errors, tb_errors, transfers);
		if (check_errors + tb_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
src/ex_pkg.sv
src/ex_alu.sv
src/ex_multiplier.sv
src/ex_control.sv
src/ex_stage.sv
verification/ex_checker.sv
verification/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - src/ex_pkg.sv
  - src/ex_alu.sv
  - src/ex_multiplier.sv
  - src/ex_control.sv
  - src/ex_stage.sv
  - target: test
    files:
      - verification/ex_checker.sv
      - verification/tb_ex_stage.sv
